// File: vdp_cmd_consts.svh
`ifndef VDP_CMD_CONSTS_SVH
`define VDP_CMD_CONSTS_SVH

// Command codes, upper nibble of R46
`define VDP_CMD_HMMV  4'b1100
`define VDP_CMD_LMMV  4'b1000
`define VDP_CMD_PSET  4'b0101
`define VDP_CMD_POINT 4'b0100
`define VDP_CMD_STOP  4'b0000

// Logic operations, R46 bits 2:0
`define VDP_LOP_IMP 3'b000
`define VDP_LOP_AND 3'b001
`define VDP_LOP_OR  3'b010
`define VDP_LOP_XOR 3'b011
`define VDP_LOP_NOT 3'b100

// Register numbers relative to R32
`define VDP_REG_SX_L 4'h0
`define VDP_REG_SX_H 4'h1
`define VDP_REG_SY_L 4'h2
`define VDP_REG_SY_H 4'h3
`define VDP_REG_DX_L 4'h4
`define VDP_REG_DX_H 4'h5
`define VDP_REG_DY_L 4'h6
`define VDP_REG_DY_H 4'h7
`define VDP_REG_NX_L 4'h8
`define VDP_REG_NX_H 4'h9
`define VDP_REG_NY_L 4'hA
`define VDP_REG_NY_H 4'hB
`define VDP_REG_CLR  4'hC
`define VDP_REG_ARG  4'hD
`define VDP_REG_CMR  4'hE

`define VDP_X_W    10
`define VDP_Y_W    10
`define VDP_ADDR_W 17

// Pixel width masks per packing
`define VDP_MASK_BPP4 8'h0F
`define VDP_MASK_BPP2 8'h03

// x[9:8] pattern of the right edge, 256 and 512 pixel modes
`define VDP_EDGE_LO 2'b01
`define VDP_EDGE_HI 2'b10

`endif

// File: vdp_cmd_pkg.sv
`default_nettype none

package vdp_cmd_pkg;

  typedef enum logic [3:0] {
    IDLE,
    CHK_LOOP,
    RD_VRAM,
    WAIT_RD_VRAM,
    PRE_RD_VRAM,
    WAIT_PRE_RD_VRAM,
    WR_VRAM,
    WAIT_WR_VRAM,
    EXEC_END
  } cmd_state_e;

  // One VRAM byte, lower x sits in the higher bits
  typedef union packed {
    logic [7:0]      whole;  // G7
    logic [1:0][3:0] p4;     // G4, G6
    logic [3:0][1:0] p2;     // G5
  } vram_byte_u;

  // Pixel packing of the active bitmap mode
  typedef enum logic [1:0] {
    BPP8,
    BPP4,
    BPP2
  } pix_mode_e;

endpackage

`default_nettype wire

// File: vdp_cmd_regs_if.sv
`default_nettype none
`timescale 1ns/10ps
`include "vdp_cmd_consts.svh"

interface vdp_cmd_regs_if;
  logic [`VDP_X_W-1:0] sx;
  logic [`VDP_Y_W-1:0] sy;
  logic [`VDP_X_W-1:0] dx;
  logic [`VDP_Y_W-1:0] dy;
  logic [`VDP_X_W-1:0] nx;
  logic [`VDP_Y_W-1:0] ny;
  logic                dix;
  logic                diy;
  logic [2:0]          lop;
  logic                timp;
  logic [3:0]          cmd;
  logic [7:0]          clr;
  logic                start;     // Held until accept
  logic                accept;
  logic                clr_load;  // POINT result back into clr
  logic [7:0]          clr_data;

  modport regs (
    output sx, sy, dx, dy, nx, ny, dix, diy, lop, timp, cmd, clr, start,
    input  accept, clr_load, clr_data
  );

  modport engine (
    input  sx, sy, dx, dy, nx, ny, dix, diy, cmd, start,
    output accept, clr_load, clr_data
  );
endinterface

`default_nettype wire

// File: vdp_cmd_regs.sv
`default_nettype none
`timescale 1ns/10ps
`include "vdp_cmd_consts.svh"

module vdp_cmd_regs (
  input  logic        reset,
  input  logic        clk,
  input  logic        reg_wr_req,
  input  logic [3:0]  reg_num,
  input  logic [7:0]  reg_data,
  input  logic        cmd_enable,
  output logic        reg_wr_ack,
  vdp_cmd_regs_if.regs cmd_if
);

  logic [7:0] cmr;  // R46

  assign cmd_if.cmd  = cmr[7:4];
  assign cmd_if.timp = cmr[3];
  assign cmd_if.lop  = cmr[2:0];

  // reset is the clock and clk the async reset on this core
  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      reg_wr_ack   <= 1'b0;
      cmd_if.start <= 1'b0;
      cmr          <= '0;
      cmd_if.sx    <= '0;
      cmd_if.sy    <= '0;
      cmd_if.dx    <= '0;
      cmd_if.dy    <= '0;
      cmd_if.nx    <= '0;
      cmd_if.ny    <= '0;
      cmd_if.dix   <= 1'b0;
      cmd_if.diy   <= 1'b0;
      cmd_if.clr   <= '0;
    end else begin
      if (cmd_if.accept)
        cmd_if.start <= 1'b0;
      if (cmd_if.clr_load)
        cmd_if.clr <= cmd_if.clr_data;  // POINT result

      // One pending CPU write per clock
      if (reg_wr_req != reg_wr_ack) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          `VDP_REG_SX_L: cmd_if.sx[7:0] <= reg_data;
          `VDP_REG_SX_H: cmd_if.sx[`VDP_X_W-1:8] <= reg_data[`VDP_X_W-9:0];
          `VDP_REG_SY_L: cmd_if.sy[7:0] <= reg_data;
          `VDP_REG_SY_H: cmd_if.sy[`VDP_Y_W-1:8] <= reg_data[`VDP_Y_W-9:0];
          `VDP_REG_DX_L: cmd_if.dx[7:0] <= reg_data;
          `VDP_REG_DX_H: cmd_if.dx[`VDP_X_W-1:8] <= reg_data[`VDP_X_W-9:0];
          `VDP_REG_DY_L: cmd_if.dy[7:0] <= reg_data;
          `VDP_REG_DY_H: cmd_if.dy[`VDP_Y_W-1:8] <= reg_data[`VDP_Y_W-9:0];
          `VDP_REG_NX_L: cmd_if.nx[7:0] <= reg_data;
          `VDP_REG_NX_H: cmd_if.nx[`VDP_X_W-1:8] <= reg_data[`VDP_X_W-9:0];
          `VDP_REG_NY_L: cmd_if.ny[7:0] <= reg_data;
          `VDP_REG_NY_H: cmd_if.ny[`VDP_Y_W-1:8] <= reg_data[`VDP_Y_W-9:0];
          `VDP_REG_CLR:  cmd_if.clr <= reg_data;
          `VDP_REG_ARG: begin
            cmd_if.dix <= reg_data[2];
            cmd_if.diy <= reg_data[3];
          end
          `VDP_REG_CMR: begin
            // New command, also aborts a running one
            cmr          <= reg_data;
            cmd_if.start <= cmd_enable;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: vdp_pixel_alu.sv
`default_nettype none
`timescale 1ns/10ps
`include "vdp_cmd_consts.svh"

module vdp_pixel_alu (
  input  vdp_cmd_pkg::pix_mode_e  mode,
  input  logic [1:0]              x_low,
  input  logic                    byte_cmd,
  input  logic [2:0]              lop,
  input  logic                    timp,
  input  logic [7:0]              src_color,
  input  vdp_cmd_pkg::vram_byte_u rd_byte,
  output logic [7:0]              rd_point,
  output logic [7:0]              wr_byte
);

  logic [7:0]              col_mask;
  logic [7:0]              src_m;
  logic [7:0]              lop_res;
  vdp_cmd_pkg::vram_byte_u merged;

  // Addressed pixel out of the byte
  always_comb begin
    case (mode)
      vdp_cmd_pkg::BPP4: rd_point = {4'h0, rd_byte.p4[~x_low[0]]};
      vdp_cmd_pkg::BPP2: rd_point = {6'h00, rd_byte.p2[~x_low]};
      default:           rd_point = rd_byte.whole;
    endcase
  end

  always_comb begin
    if (byte_cmd)
      col_mask = 8'hFF;  // Whole byte moves
    else if (mode == vdp_cmd_pkg::BPP4)
      col_mask = `VDP_MASK_BPP4;
    else if (mode == vdp_cmd_pkg::BPP2)
      col_mask = `VDP_MASK_BPP2;
    else
      col_mask = 8'hFF;
  end

  assign src_m = src_color & col_mask;

  always_comb begin
    if (timp && src_m == 8'h00) begin
      lop_res = rd_point;  // Transparent, keep destination
    end else begin
      case (lop)
        `VDP_LOP_IMP: lop_res = src_m;
        `VDP_LOP_AND: lop_res = src_m & rd_point;
        `VDP_LOP_OR:  lop_res = src_m | rd_point;
        `VDP_LOP_XOR: lop_res = src_m ^ rd_point;
        `VDP_LOP_NOT: lop_res = ~src_m & col_mask;
        default:      lop_res = rd_point;
      endcase
    end
  end

  // Result pixel back into its slot, neighbours untouched
  always_comb begin
    merged = rd_byte;
    case (mode)
      vdp_cmd_pkg::BPP4: merged.p4[~x_low[0]] = lop_res[3:0];
      vdp_cmd_pkg::BPP2: merged.p2[~x_low] = lop_res[1:0];
      default:           merged.whole = lop_res;
    endcase
  end

  assign wr_byte = byte_cmd ? src_m : merged.whole;

endmodule

`default_nettype wire

// File: vdp_cmd_engine.sv
`default_nettype none
`timescale 1ns/10ps
`include "vdp_cmd_consts.svh"

module vdp_cmd_engine (
  input  logic                   reset,
  input  logic                   clk,
  input  logic                   stall,
  input  vdp_cmd_pkg::pix_mode_e mode,
  input  logic                   high_res,  // G5 or G6, 512 pixel rows
  vdp_cmd_regs_if.engine         cmd_if,
  output logic                   vram_rd_req,
  input  logic                   vram_rd_ack,
  output logic                   vram_wr_req,
  input  logic                   vram_wr_ack,
  output logic [`VDP_ADDR_W-1:0] vram_addr,
  output logic [7:0]             vram_wr_data,
  output logic                   ce,
  input  logic [7:0]             rd_point,
  input  logic [7:0]             wr_byte,
  output logic [1:0]             x_low,
  output logic                   byte_cmd
);

  vdp_cmd_pkg::cmd_state_e state;

  logic [`VDP_X_W-1:0] dx_tmp;
  logic [`VDP_X_W-1:0] nx_tmp;
  logic [`VDP_Y_W-1:0] dy_tmp;
  logic [`VDP_Y_W-1:0] ny_tmp;
  logic [`VDP_X_W-1:0] acc_x;     // Address of the current access
  logic [`VDP_Y_W-1:0] acc_y;
  logic [1:0]          pix_x_low;
  logic                first_pass;
  logic [`VDP_X_W-1:0] nx_count;
  logic [`VDP_X_W-1:0] x_mag;
  logic [`VDP_X_W-1:0] x_step;
  logic [`VDP_Y_W-1:0] y_step;
  logic [1:0]          edge_mask;
  logic                fill_cmd;
  logic                nx_loop_end;
  logic                ny_loop_end;
  logic                rd_done;
  logic                wr_done;
  logic                vram_idle;

  assign byte_cmd  = cmd_if.cmd[3:2] == 2'b11;
  assign fill_cmd  = cmd_if.cmd == `VDP_CMD_HMMV || cmd_if.cmd == `VDP_CMD_LMMV;
  assign rd_done   = vram_rd_req == vram_rd_ack;
  assign wr_done   = vram_wr_req == vram_wr_ack;
  assign vram_idle = rd_done && wr_done;
  assign x_low     = pix_x_low;

  // Byte commands count and step in bytes
  always_comb begin
    if (byte_cmd && mode == vdp_cmd_pkg::BPP4) begin
      nx_count = cmd_if.nx >> 1;
      x_mag    = `VDP_X_W'(2);
    end else if (byte_cmd && mode == vdp_cmd_pkg::BPP2) begin
      nx_count = cmd_if.nx >> 2;
      x_mag    = `VDP_X_W'(4);
    end else begin
      nx_count = cmd_if.nx;
      x_mag    = `VDP_X_W'(1);
    end
  end

  assign x_step = cmd_if.dix ? -x_mag : x_mag;
  assign y_step = cmd_if.diy ? '1 : `VDP_Y_W'(1);

  assign edge_mask   = high_res ? `VDP_EDGE_HI : `VDP_EDGE_LO;
  assign nx_loop_end = fill_cmd ?
                       (nx_tmp == '0 || (dx_tmp[`VDP_X_W-1:8] & edge_mask) == edge_mask) :
                       1'b1;
  assign ny_loop_end = ny_tmp == `VDP_Y_W'(1) || (cmd_if.diy && dy_tmp == '0);

  always_comb begin
    case (mode)
      vdp_cmd_pkg::BPP2: vram_addr = {acc_y[9:0], acc_x[8:2]};  // G5
      vdp_cmd_pkg::BPP4: vram_addr = high_res ? {acc_y[8:0], acc_x[8:1]}   // G6
                                              : {acc_y[9:0], acc_x[7:1]};  // G4
      default:           vram_addr = {acc_y[8:0], acc_x[7:0]};  // G7
    endcase
  end

  assign cmd_if.accept   = state == vdp_cmd_pkg::IDLE && cmd_if.start && !stall;
  assign cmd_if.clr_load = state == vdp_cmd_pkg::WAIT_RD_VRAM && rd_done &&
                           !cmd_if.start && !stall;
  assign cmd_if.clr_data = rd_point;

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      state        <= vdp_cmd_pkg::IDLE;
      ce           <= 1'b0;
      vram_rd_req  <= 1'b0;
      vram_wr_req  <= 1'b0;
      first_pass   <= 1'b0;
      dx_tmp       <= '0;
      nx_tmp       <= '0;
      dy_tmp       <= '0;
      ny_tmp       <= '0;
      acc_x        <= '0;
      acc_y        <= '0;
      pix_x_low    <= '0;
      vram_wr_data <= '0;
    end else if (!stall) begin
      if (cmd_if.start && state != vdp_cmd_pkg::IDLE) begin
        state <= vdp_cmd_pkg::IDLE;  // Abort by R46 write
        ce    <= 1'b0;
      end else begin
        case (state)
          vdp_cmd_pkg::IDLE: begin
            if (cmd_if.start) begin
              ce         <= 1'b1;
              dx_tmp     <= cmd_if.dx;
              dy_tmp     <= cmd_if.dy;
              nx_tmp     <= nx_count;
              ny_tmp     <= cmd_if.ny;
              first_pass <= 1'b1;
              state      <= vdp_cmd_pkg::CHK_LOOP;
            end
          end
          vdp_cmd_pkg::CHK_LOOP: begin
            first_pass <= 1'b0;
            if (!first_pass && nx_loop_end && ny_loop_end) begin
              state <= vdp_cmd_pkg::EXEC_END;
            end else begin
              case (cmd_if.cmd)
                `VDP_CMD_HMMV:               state <= vdp_cmd_pkg::WR_VRAM;
                `VDP_CMD_LMMV, `VDP_CMD_PSET: state <= vdp_cmd_pkg::PRE_RD_VRAM;
                `VDP_CMD_POINT:              state <= vdp_cmd_pkg::RD_VRAM;
                `VDP_CMD_STOP:               state <= vdp_cmd_pkg::EXEC_END;
                default:                     state <= vdp_cmd_pkg::EXEC_END;
              endcase
            end
            // Next row
            if (!first_pass && nx_loop_end) begin
              nx_tmp <= nx_count;
              dx_tmp <= cmd_if.dx;
              ny_tmp <= ny_tmp - 1'b1;
              dy_tmp <= dy_tmp + y_step;
            end
          end
          vdp_cmd_pkg::RD_VRAM: begin
            if (vram_idle) begin
              acc_x       <= cmd_if.sx;
              acc_y       <= cmd_if.sy;
              pix_x_low   <= cmd_if.sx[1:0];
              vram_rd_req <= ~vram_rd_ack;
              state       <= vdp_cmd_pkg::WAIT_RD_VRAM;
            end
          end
          vdp_cmd_pkg::WAIT_RD_VRAM: begin
            if (rd_done)
              state <= vdp_cmd_pkg::EXEC_END;  // clr_load fires here
          end
          vdp_cmd_pkg::PRE_RD_VRAM: begin
            if (vram_idle) begin
              acc_x       <= dx_tmp;
              acc_y       <= dy_tmp;
              pix_x_low   <= dx_tmp[1:0];
              vram_rd_req <= ~vram_rd_ack;
              state       <= vdp_cmd_pkg::WAIT_PRE_RD_VRAM;
            end
          end
          vdp_cmd_pkg::WAIT_PRE_RD_VRAM: begin
            if (rd_done) begin
              vram_wr_data <= wr_byte;  // Merged destination byte
              state        <= vdp_cmd_pkg::WR_VRAM;
            end
          end
          vdp_cmd_pkg::WR_VRAM: begin
            if (vram_idle) begin
              acc_x <= dx_tmp;
              acc_y <= dy_tmp;
              if (byte_cmd)
                vram_wr_data <= wr_byte;
              vram_wr_req <= ~vram_wr_ack;
              state       <= vdp_cmd_pkg::WAIT_WR_VRAM;
            end
          end
          vdp_cmd_pkg::WAIT_WR_VRAM: begin
            if (wr_done) begin
              if (cmd_if.cmd == `VDP_CMD_PSET) begin
                state <= vdp_cmd_pkg::EXEC_END;
              end else begin
                dx_tmp <= dx_tmp + x_step;
                nx_tmp <= nx_tmp - 1'b1;
                state  <= vdp_cmd_pkg::CHK_LOOP;
              end
            end
          end
          vdp_cmd_pkg::EXEC_END: begin
            ce    <= 1'b0;
            state <= vdp_cmd_pkg::IDLE;
          end
          default: state <= vdp_cmd_pkg::IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: vdp_cmd_top.sv
`default_nettype none
`timescale 1ns/10ps
`include "vdp_cmd_consts.svh"

module vdp_cmd_top (
  input  logic                   reset,
  input  logic                   clk,
  input  logic                   mode_graphic_4,
  input  logic                   mode_graphic_5,
  input  logic                   mode_graphic_6,
  input  logic                   mode_graphic_7,
  input  logic                   reg_wr_req,
  input  logic [3:0]             reg_num,
  input  logic [7:0]             reg_data,
  output logic                   reg_wr_ack,
  output logic                   vram_rd_req,
  input  logic                   vram_rd_ack,
  input  logic [7:0]             vram_rd_data,
  output logic                   vram_wr_req,
  input  logic                   vram_wr_ack,
  output logic [7:0]             vram_wr_data,
  output logic [`VDP_ADDR_W-1:0] vram_addr,
  output logic [7:0]             clr,
  output logic                   ce,
  output logic [3:0]             current_command
);

  vdp_cmd_regs_if cmd_if ();

  vdp_cmd_pkg::pix_mode_e  mode;
  vdp_cmd_pkg::vram_byte_u rd_byte;
  logic                    cmd_enable;
  logic                    high_res;
  logic                    stall;
  logic [7:0]              rd_point;
  logic [7:0]              wr_byte;
  logic [1:0]              x_low;
  logic                    byte_cmd;

  assign cmd_enable = mode_graphic_4 | mode_graphic_5 | mode_graphic_6 | mode_graphic_7;
  assign high_res   = mode_graphic_5 | mode_graphic_6;
  assign stall      = reg_wr_req != reg_wr_ack;  // CPU writes go first

  always_comb begin
    if (mode_graphic_5)
      mode = vdp_cmd_pkg::BPP2;
    else if (mode_graphic_4 || mode_graphic_6)
      mode = vdp_cmd_pkg::BPP4;
    else
      mode = vdp_cmd_pkg::BPP8;
  end

  assign rd_byte         = vram_rd_data;
  assign clr             = cmd_if.clr;
  assign current_command = cmd_if.cmd;

  vdp_cmd_regs u_regs (
    .reset      (reset),
    .clk        (clk),
    .reg_wr_req (reg_wr_req),
    .reg_num    (reg_num),
    .reg_data   (reg_data),
    .cmd_enable (cmd_enable),
    .reg_wr_ack (reg_wr_ack),
    .cmd_if     (cmd_if.regs)
  );

  vdp_cmd_engine u_engine (
    .reset        (reset),
    .clk          (clk),
    .stall        (stall),
    .mode         (mode),
    .high_res     (high_res),
    .cmd_if       (cmd_if.engine),
    .vram_rd_req  (vram_rd_req),
    .vram_rd_ack  (vram_rd_ack),
    .vram_wr_req  (vram_wr_req),
    .vram_wr_ack  (vram_wr_ack),
    .vram_addr    (vram_addr),
    .vram_wr_data (vram_wr_data),
    .ce           (ce),
    .rd_point     (rd_point),
    .wr_byte      (wr_byte),
    .x_low        (x_low),
    .byte_cmd     (byte_cmd)
  );

  vdp_pixel_alu u_alu (
    .mode      (mode),
    .x_low     (x_low),
    .byte_cmd  (byte_cmd),
    .lop       (cmd_if.lop),
    .timp      (cmd_if.timp),
    .src_color (cmd_if.clr),
    .rd_byte   (rd_byte),
    .rd_point  (rd_point),
    .wr_byte   (wr_byte)
  );

endmodule

`default_nettype wire

// File: vdp_cmd_props.sv
`default_nettype none
`timescale 1ns/10ps

module vdp_cmd_props (
  input logic reset,
  input logic clk,
  input logic ce,
  input logic reg_wr_req,
  input logic reg_wr_ack,
  input logic vram_rd_req,
  input logic vram_rd_ack,
  input logic vram_wr_req,
  input logic vram_wr_ack
);

  logic rd_pend;
  logic wr_pend;

  assign rd_pend = vram_rd_req != vram_rd_ack;
  assign wr_pend = vram_wr_req != vram_wr_ack;

  // Request level is frozen while its access is open
  a_rd_hold: assert property (@(posedge reset) disable iff (clk) rd_pend |=> $stable(vram_rd_req))
    else $error("read request changed while pending");
  a_wr_hold: assert property (@(posedge reset) disable iff (clk) wr_pend |=> $stable(vram_wr_req))
    else $error("write request changed while pending");
  a_one_open: assert property (@(posedge reset) disable iff (clk) !(rd_pend && wr_pend))
    else $error("read and write pending together");

  a_ce_reset: assert property (@(posedge reset) $fell(clk) |-> !ce)
    else $error("ce high after reset");

  a_ack_toggle: assert property (@(posedge reset) disable iff (clk)
                                 (reg_wr_ack != $past(reg_wr_ack)) |->
                                 $past(reg_wr_req != reg_wr_ack))
    else $error("reg_wr_ack toggled without a pending write");

endmodule

bind vdp_cmd_top vdp_cmd_props u_props (
  .reset       (reset),
  .clk         (clk),
  .ce          (ce),
  .reg_wr_req  (reg_wr_req),
  .reg_wr_ack  (reg_wr_ack),
  .vram_rd_req (vram_rd_req),
  .vram_rd_ack (vram_rd_ack),
  .vram_wr_req (vram_wr_req),
  .vram_wr_ack (vram_wr_ack)
);

`default_nettype wire

// File: tb_vdp_cmd.sv
`default_nettype none
`timescale 1ns/10ps
`include "vdp_cmd_consts.svh"

module tb_vdp_cmd;

  logic        reset;  // Clock
  logic        clk;    // Async reset, active high
  logic        mode_graphic_4, mode_graphic_5, mode_graphic_6, mode_graphic_7;
  logic        reg_wr_req, reg_wr_ack;
  logic [3:0]  reg_num, current_command;
  logic [7:0]  reg_data, clr, vram_rd_data, vram_wr_data;
  logic        vram_rd_req, vram_rd_ack, vram_wr_req, vram_wr_ack, ce;
  logic [16:0] vram_addr;
  logic [7:0]  vram [0:131071];
  logic [7:0]  ref_mem [0:131071];  // Expected VRAM contents
  int          rd_cnt, wr_cnt, errors, checks;

  vdp_cmd_top dut (.*);

  initial begin
    reset = 1'b0;
    forever #4 reset = ~reset;
  end

  initial begin
    repeat (40000) @(posedge reset);  // Longest fill plus register traffic, with margin
    $display("Watchdog timeout: command did not finish in 40000 cycles");
    $display("Simulation failed");
    $finish;
  end

  // VRAM model, random ack latency of 1 to 4 cycles
  always @(posedge reset) begin
    if (rd_cnt == 0 && vram_rd_req != vram_rd_ack) begin
      rd_cnt <= 1 + ($urandom % 4);
    end else if (rd_cnt == 1) begin
      vram_rd_data <= vram[vram_addr];
      vram_rd_ack  <= vram_rd_req;
      rd_cnt       <= 0;
    end else if (rd_cnt > 1) begin
      rd_cnt <= rd_cnt - 1;
    end
    if (wr_cnt == 0 && vram_wr_req != vram_wr_ack) begin
      wr_cnt <= 1 + ($urandom % 4);
    end else if (wr_cnt == 1) begin
      vram[vram_addr] <= vram_wr_data;
      vram_wr_ack     <= vram_wr_req;
      wr_cnt          <= 0;
    end else if (wr_cnt > 1) begin
      wr_cnt <= wr_cnt - 1;
    end
  end

  task automatic report_err(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic logic [16:0] addr_of(int g, logic [9:0] x, logic [9:0] y);
    case (g)
      4: return {y[9:0], x[7:1]};
      5: return {y[9:0], x[8:2]};
      6: return {y[8:0], x[8:1]};
      default: return {y[8:0], x[7:0]};
    endcase
  endfunction

  function automatic int pix_shift(int g, logic [9:0] x);
    if (g == 5)
      return (3 - x[1:0]) * 2;  // Lower x in higher bits
    else if (g == 7)
      return 0;
    return x[0] ? 0 : 4;
  endfunction

  function automatic logic [7:0] pix_mask(int g);
    return (g == 5) ? 8'h03 : (g == 7) ? 8'hFF : 8'h0F;
  endfunction

  function automatic logic [7:0] apply_lop(int g, logic [7:0] b, logic [9:0] x,
                                           logic [2:0] lop, logic timp, logic [7:0] c);
    logic [7:0] m, dst, src, res;
    int sh;
    m   = pix_mask(g);
    sh  = pix_shift(g, x);
    dst = (b >> sh) & m;
    src = c & m;
    case (lop)
      3'd1: res = src & dst;
      3'd2: res = src | dst;
      3'd3: res = src ^ dst;
      3'd4: res = ~src & m;
      default: res = src;
    endcase
    if (timp && src == 8'h00)
      res = dst;
    return (b & ~(m << sh)) | (res << sh);
  endfunction

  task automatic write_reg(input logic [3:0] n, input logic [7:0] d);
    @(posedge reset);
    reg_num    <= n;
    reg_data   <= d;
    reg_wr_req <= ~reg_wr_req;
    @(posedge reset);
    checks++;
    assert (reg_wr_ack != reg_wr_req) else report_err("reg_wr_ack toggled too early");
    @(posedge reset);
    checks++;
    assert (reg_wr_ack == reg_wr_req) else report_err("reg_wr_ack did not toggle");
    if (n == `VDP_REG_CMR) begin
      checks++;
      assert (current_command == d[7:4]) else report_err("current_command wrong");
    end
  endtask

  task automatic set_mode(input int g);
    @(posedge reset);
    mode_graphic_4 <= g == 4;
    mode_graphic_5 <= g == 5;
    mode_graphic_6 <= g == 6;
    mode_graphic_7 <= g == 7;
  endtask

  task automatic write_coord(input logic [3:0] lo, input logic [9:0] v);
    write_reg(lo, v[7:0]);
    write_reg(lo + 4'h1, {6'h00, v[9:8]});
  endtask

  task automatic wait_done();
    while (!ce)
      @(posedge reset);
    while (ce)
      @(posedge reset);
  endtask

  task automatic compare_mem(input string what);
    for (int a = 0; a < 131072; a++) begin
      checks++;
      assert (vram[a] == ref_mem[a])
        else report_err($sformatf("%s: VRAM[%05h] %02h, expected %02h",
                                  what, a, vram[a], ref_mem[a]));
    end
  endtask

  task automatic pset_test(input int g, input logic [9:0] x, y, input logic [2:0] lop,
                           input logic [7:0] c);
    logic [16:0] a;
    set_mode(g);
    a = addr_of(g, x, y);
    ref_mem[a] = apply_lop(g, ref_mem[a], x, lop, 1'b0, c);
    write_coord(`VDP_REG_DX_L, x);
    write_coord(`VDP_REG_DY_L, y);
    write_reg(`VDP_REG_CLR, c);
    write_reg(`VDP_REG_CMR, {`VDP_CMD_PSET, 1'b0, lop});
    wait_done();
    compare_mem("PSET");
  endtask

  task automatic point_test(input int g, input logic [9:0] x, y);
    logic [7:0] exp;
    set_mode(g);
    exp = (ref_mem[addr_of(g, x, y)] >> pix_shift(g, x)) & pix_mask(g);
    write_coord(`VDP_REG_SX_L, x);
    write_coord(`VDP_REG_SY_L, y);
    write_reg(`VDP_REG_CMR, {`VDP_CMD_POINT, 4'h0});
    wait_done();
    checks++;
    assert (clr == exp) else report_err($sformatf("POINT clr %02h, expected %02h", clr, exp));
  endtask

  // HMMV when hmmv is set, else LMMV; abort restarts the same command midway
  task automatic fill_test(input int g, input logic hmmv, input logic [9:0] dx, dy, nx, ny,
                           input logic dix, diy, input logic [2:0] lop, input logic timp,
                           input logic [7:0] c, input logic abort);
    logic [9:0] x, y, step, cnt;
    logic [7:0] cmr;
    set_mode(g);
    step = hmmv ? ((g == 4 || g == 6) ? 10'd2 : (g == 5) ? 10'd4 : 10'd1) : 10'd1;
    cnt  = hmmv ? nx / step : nx;
    y = dy;
    for (int r = 0; r < ny; r++) begin
      x = dx;
      for (int i = 0; i < cnt && x < ((g == 5 || g == 6) ? 512 : 256); i++) begin
        if (hmmv)
          ref_mem[addr_of(g, x, y)] = c;
        else
          ref_mem[addr_of(g, x, y)] = apply_lop(g, ref_mem[addr_of(g, x, y)], x, lop, timp, c);
        x = dix ? x - step : x + step;
      end
      if (diy && y == 0)
        break;
      y = diy ? y - 1 : y + 1;
    end
    cmr = hmmv ? {`VDP_CMD_HMMV, 4'h0} : {`VDP_CMD_LMMV, timp, lop};
    write_coord(`VDP_REG_DX_L, dx);
    write_coord(`VDP_REG_DY_L, dy);
    write_coord(`VDP_REG_NX_L, nx);
    write_coord(`VDP_REG_NY_L, ny);
    write_reg(`VDP_REG_CLR, c);
    write_reg(`VDP_REG_ARG, {4'h0, diy, dix, 2'b00});
    write_reg(`VDP_REG_CMR, cmr);
    if (abort) begin
      while (!ce)
        @(posedge reset);
      repeat (30) @(posedge reset);
      write_reg(`VDP_REG_CMR, cmr);
      @(posedge reset);
      checks++;
      assert (!ce) else report_err("R46 write did not abort the command");
    end
    wait_done();
    compare_mem(hmmv ? "HMMV" : "LMMV");
  endtask

  initial begin
    void'($urandom(66));
    clk = 1'b1;
    {mode_graphic_4, mode_graphic_5, mode_graphic_6, mode_graphic_7} = 4'b0001;
    reg_wr_req = 1'b0;
    reg_num = '0;
    reg_data = '0;
    vram_rd_ack = 1'b0;
    vram_wr_ack = 1'b0;
    vram_rd_data = '0;
    rd_cnt = 0;
    wr_cnt = 0;
    errors = 0;
    checks = 0;
    for (int a = 0; a < 131072; a++) begin
      vram[a]    = 8'((a * 37) ^ (a >> 9) ^ (a >> 16));
      ref_mem[a] = vram[a];
    end
    repeat (8) @(posedge reset);
    clk <= 1'b0;
    @(posedge reset);
    checks++;
    assert (!ce) else report_err("ce high after reset");

    for (int l = 0; l < 5; l++) begin
      pset_test(5, 10'($urandom % 512), 10'($urandom % 212), 3'(l), 8'($urandom));
      pset_test(4, 10'($urandom % 256), 10'($urandom % 212), 3'(l), 8'($urandom));
    end
    point_test(6, 10'd301, 10'd77);
    point_test(6, 10'd12, 10'd200);
    point_test(7, 10'd5, 10'd3);
    point_test(7, 10'd255, 10'd150);
    fill_test(7, 1'b1, 10'd250, 10'd5, 10'd10, 10'd2, 1'b0, 1'b0, 3'd0, 1'b0, 8'($urandom), 1'b0);
    fill_test(4, 1'b1, 10'd10, 10'd1, 10'd8, 10'd4, 1'b1, 1'b1, 3'd0, 1'b0, 8'($urandom), 1'b0);
    fill_test(5, 1'b0, 10'd100, 10'd20, 10'd12, 10'd3, 1'b0, 1'b0, 3'd3, 1'b1, 8'h00, 1'b0);
    fill_test(5, 1'b0, 10'd505, 10'd30, 10'd12, 10'd2, 1'b0, 1'b0, 3'd3, 1'b0, 8'hFF, 1'b0);
    fill_test(6, 1'b0, 10'd40, 10'd9, 10'd9, 10'd2, 1'b0, 1'b0, 3'd3, 1'b0, 8'($urandom) | 8'h01,
              1'b0);
    fill_test(7, 1'b1, 10'd0, 10'd40, 10'd120, 10'd3, 1'b0, 1'b0, 3'd0, 1'b0, 8'($urandom), 1'b1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
vdp_cmd_pkg.sv
vdp_cmd_regs_if.sv
vdp_cmd_regs.sv
vdp_pixel_alu.sv
vdp_cmd_engine.sv
vdp_cmd_top.sv
vdp_cmd_props.sv
tb_vdp_cmd.sv

// File: run.sh
#!/bin/sh
set -e
set -o pipefail 2>/dev/null || true
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_vdp_cmd -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
grep -q "Simulation completed successfully" sim.log
